/* compile.f */
+incdir+testbench
hdl/rv32_pkg.sv
hdl/decode_if.sv
hdl/rv32_fetch.sv
hdl/rv32_decoder.sv
hdl/rv32_regfile.sv
hdl/rv32_alu.sv
hdl/rv32_lsu.sv
hdl/rv32_core.sv
testbench/tb_rv32_core.sv

/* Bender.yml */
package:
  name: rv32_core

sources:
  - files:
      - hdl/rv32_pkg.sv
      - hdl/decode_if.sv
      - hdl/rv32_fetch.sv
      - hdl/rv32_decoder.sv
      - hdl/rv32_regfile.sv
      - hdl/rv32_alu.sv
      - hdl/rv32_lsu.sv
      - hdl/rv32_core.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_rv32_core.sv

/* testbench/tb_rv32_model.svh */
/* Reference RV32I model and random number generator for the core testbench.
   Included into the test top; model_step executes one instruction per call. */
`ifndef TB_RV32_MODEL_SVH
`define TB_RV32_MODEL_SVH

    word_t       lcg_state = 32'd29310;
    word_t       m_imem [1024];
    word_t       m_dmem [1024];
    word_t       m_regs [32];
    word_t       m_pc;
    logic        m_halted;
    halt_cause_t m_cause;

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Low LCG bits are weak, so take the upper ones
    function automatic int unsigned rand_below(int unsigned n);
        word_t r;
        r = lcg_next();
        return (r >> 8) % n;
    endfunction

    function automatic word_t rand_word();
        word_t hi, lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi[31:16], lo[31:16]};
    endfunction

    // funct3 selects the operation; alt marks SUB and the arithmetic shift
    function automatic word_t alu_calc(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_cond(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // ==========================================================================
    // One instruction, returns the expected retire record
    // ==========================================================================
    task automatic model_step(output word_t e_pc, output word_t e_rd, output word_t e_data);
        word_t      ins, a, b, imm_i, imm_s, imm_b, imm_j, res, nxt, addr;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       wr, bad, alt;
        ins   = m_imem[m_pc[11:2]];
        f3    = ins[14:12];
        f7    = ins[31:25];
        a     = m_regs[ins[19:15]];
        b     = m_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        nxt   = m_pc + 32'd4;
        res   = '0;
        wr    = 1'b0;
        bad   = 1'b0;
        case (ins[6:0])
            7'b0110111: begin   // LUI
                res = {ins[31:12], 12'b0};
                wr  = 1'b1;
            end
            7'b0010111: begin   // AUIPC
                res = m_pc + {ins[31:12], 12'b0};
                wr  = 1'b1;
            end
            7'b1101111: begin   // JAL
                res = m_pc + 32'd4;
                wr  = 1'b1;
                nxt = m_pc + imm_j;
            end
            7'b1100111: begin   // JALR
                bad = (f3 != 3'd0);
                res = m_pc + 32'd4;
                wr  = 1'b1;
                nxt = (a + imm_i) & ~32'd1;
            end
            7'b1100011: begin
                bad = (f3 == 3'd2) || (f3 == 3'd3);
                if (branch_cond(f3, a, b)) nxt = m_pc + imm_b;
            end
            7'b0000011: begin   // Word loads only
                bad  = (f3 != 3'd2);
                addr = a + imm_i;
                res  = m_dmem[addr[11:2]];
                wr   = 1'b1;
            end
            7'b0100011: begin
                bad  = (f3 != 3'd2);
                addr = a + imm_s;
                if (!bad) m_dmem[addr[11:2]] = b;
            end
            7'b0010011: begin
                alt = (f3 == 3'd5) && (f7 == 7'h20);
                bad = ((f3 == 3'd1) && (f7 != 7'h00)) ||
                      ((f3 == 3'd5) && (f7 != 7'h00) && (f7 != 7'h20));
                res = alu_calc(f3, alt, a, imm_i);
                wr  = 1'b1;
            end
            7'b0110011: begin
                alt = (f7 == 7'h20);
                bad = !((f7 == 7'h00) || (alt && ((f3 == 3'd0) || (f3 == 3'd5))));
                res = alu_calc(f3, alt, a, b);
                wr  = 1'b1;
            end
            7'b1110011: begin   // Only ECALL and EBREAK exist here
                if (ins == 32'h0000_0073) m_cause = halt_ecall;
                else if (ins == 32'h0010_0073) m_cause = halt_ebreak;
                else bad = 1'b1;
            end
            default: bad = 1'b1;
        endcase
        if (bad) m_cause = halt_illegal;
        if (m_cause != halt_none) begin
            m_halted = 1'b1;
            wr       = 1'b0;
            nxt      = m_pc + 32'd4;
        end
        e_pc   = m_pc;
        e_rd   = '0;
        e_data = '0;
        if (wr && (ins[11:7] != 5'd0)) begin
            e_rd              = word_t'(ins[11:7]);
            e_data            = res;
            m_regs[ins[11:7]] = res;
        end
        m_pc = {20'b0, nxt[11:2], 2'b00};   // 4 KiB wrap
    endtask

`endif

/* testbench/tb_rv32_core.sv */
/* Testbench for the single-cycle RV32I core. Loads random programs while
   run is low, runs them and checks each retire record against the model. */
module tb_rv32_core import rv32_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    logic        clk = 1'b0;
    logic        rst;
    logic        run;
    logic        load_en;
    logic [9:0]  load_index;
    logic [31:0] load_data;
    logic        halted;
    logic [1:0]  halt_cause;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;
    word_t       prog [$];

    `include "tb_rv32_model.svh"

    rv32_core rv32_core_inst (
        .clk          (clk),
        .rst          (rst),
        .run          (run),
        .load_en      (load_en),
        .load_index   (load_index),
        .load_data    (load_data),
        .halted       (halted),
        .halt_cause   (halt_cause),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    // ==========================================================================
    // Program generation
    // ==========================================================================
    function automatic void emit_alu();
        int unsigned kind, f3;
        reg_idx_t    rd, rs1, rs2;
        logic [11:0] imm;
        logic        alt;
        word_t       r;
        kind = rand_below(8);
        f3   = rand_below(8);
        rd   = reg_idx_t'(rand_below(31));      // x31 stays the memory base
        rs1  = reg_idx_t'(rand_below(32));
        rs2  = reg_idx_t'(rand_below(32));
        alt  = (rand_below(2) == 1);
        imm  = 12'(rand_below(4096));
        r    = rand_word();
        if (kind < 3) begin
            if (f3 == 1) imm = {7'b0, imm[4:0]};
            if (f3 == 5) imm = {alt ? f7_alt : f7_base, imm[4:0]};
            prog.push_back({imm, rs1, 3'(f3), rd, opc_op_imm});
        end else if (kind < 6) begin
            alt = alt && ((f3 == 0) || (f3 == 5));
            prog.push_back({alt ? f7_alt : f7_base, rs2, rs1, 3'(f3), rd, opc_op});
        end else begin
            prog.push_back({r[31:12], rd, (kind == 6) ? opc_lui : opc_auipc});
        end
    endfunction

    // SW then LW of the same word through the other base register
    function automatic void emit_mem();
        int unsigned w;
        reg_idx_t    src, dest, st_base, ld_base;
        logic [11:0] st_off, ld_off;
        w       = rand_below(64);
        src     = reg_idx_t'(rand_below(32));
        dest    = reg_idx_t'(rand_below(31));
        st_off  = 12'(4 * w + rand_below(4));   // Low bits are ignored
        ld_off  = 12'(4 * w + rand_below(4));
        st_base = (rand_below(2) == 0) ? 5'd0 : 5'd31;
        ld_base = (st_base == 5'd0) ? 5'd31 : 5'd0;
        prog.push_back({st_off[11:5], src, st_base, f3_word, st_off[4:0], opc_store});
        prog.push_back({ld_off, ld_base, f3_word, dest, opc_load});
    endfunction

    // Forward branch, JAL or AUIPC+JALR over 1 to 4 filler instructions
    function automatic void emit_jump();
        int unsigned kind, skip, f3;
        reg_idx_t    rd, rx, rs1, rs2;
        logic [12:0] boff;
        logic [20:0] joff;
        logic [11:0] ioff;
        kind = rand_below(3);
        skip = 1 + rand_below(4);
        rd   = reg_idx_t'(rand_below(31));
        rx   = reg_idx_t'(1 + rand_below(30));
        rs1  = reg_idx_t'(rand_below(32));
        rs2  = reg_idx_t'(rand_below(32));
        if (rand_below(4) == 0) rs2 = rs1;
        f3   = rand_below(6);
        if (f3 >= 2) f3 = f3 + 2;               // Skip the two unused encodings
        boff = 13'(4 * (skip + 1));
        joff = 21'(4 * (skip + 1));
        ioff = 12'(8 + 4 * skip);               // Relative to the AUIPC
        case (kind)
            0: prog.push_back({boff[12], boff[10:5], rs2, rs1, 3'(f3), boff[4:1], boff[11],
                               opc_branch});
            1: prog.push_back({joff[20], joff[10:1], joff[11], joff[19:12], rd, opc_jal});
            default: begin
                prog.push_back({20'h0, rx, opc_auipc});
                prog.push_back({ioff, rx, 3'b000, rd, opc_jalr});
            end
        endcase
        repeat (skip) emit_alu();
    endfunction

    function automatic void build_main_program();
        word_t       r;
        logic [11:0] off;
        prog.delete();
        for (int i = 1; i < 32; i++) begin      // Every register gets a value
            r = rand_word();
            prog.push_back({r[31:12], 5'(i), opc_lui});
            if (i < 31) prog.push_back({r[11:0], 5'(i), 3'b000, 5'(i), opc_op_imm});
        end
        for (int w = 0; w < 64; w++) begin      // Fill the data window
            off = 12'(4 * w);
            prog.push_back({off[11:5], 5'(1 + w % 30), 5'd0, f3_word, off[4:0], opc_store});
        end
        for (int n = 0; n < 150; n++) begin
            case (rand_below(4))
                0:       emit_mem();
                1:       emit_jump();
                default: emit_alu();
            endcase
        end
        prog.push_back(instr_ecall);
    endfunction

    function automatic void build_halt_program(input word_t last);
        prog.delete();
        repeat (3 + rand_below(4)) emit_alu();
        prog.push_back(last);
    endfunction

    // ==========================================================================
    // Reset, load and run
    // ==========================================================================
    task automatic reset_core();
        @(posedge clk);
        #1;
        rst = 1'b1;
        run = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst      = 1'b0;
        m_pc     = '0;
        m_halted = 1'b0;
        m_cause  = halt_none;
        @(negedge clk);
        check_value("retire_valid", retire_valid, 32'd0);
        check_value("halted", halted, 32'd0);
        check_value("halt_cause", halt_cause, halt_none);
        check_value("retire_pc", retire_pc, 32'd0);
    endtask

    task automatic load_program();
        foreach (prog[i]) begin
            @(posedge clk);
            #1;
            load_en    = 1'b1;
            load_index = mem_idx_t'(i);
            load_data  = prog[i];
            m_imem[i]  = prog[i];
            @(negedge clk);
            check_value("retire_valid", retire_valid, 32'd0);
            check_value("halted", halted, 32'd0);
        end
        @(posedge clk);
        #1;
        load_en = 1'b0;
    endtask

    task automatic run_program(input halt_cause_t exp_cause, input int unsigned limit);
        word_t       e_pc, e_rd, e_data;
        int unsigned cycles;
        @(posedge clk);
        #1;
        run    = 1'b1;
        cycles = 0;
        while (!m_halted) begin
            @(negedge clk);
            check_value("halted", halted, 32'd0);
            check_value("retire_valid", retire_valid, 32'd1);
            model_step(e_pc, e_rd, e_data);
            check_value("retire_pc", retire_pc, e_pc);
            check_value("retire_rd", retire_rd, e_rd);
            check_value("retire_data", retire_data, e_data);
            cycles++;
            if ((cycles >= limit) && !m_halted) begin
                $display("Timeout, the core did not halt within %0d cycles", limit);
                $display("TESTS FAILED");
                $fatal(1);
            end
        end
        // Halted one cycle after the halting instruction, then frozen
        for (int n = 0; n < 11; n++) begin
            @(negedge clk);
            check_value("halted", halted, 32'd1);
            check_value("halt_cause", halt_cause, exp_cause);
            check_value("retire_valid", retire_valid, 32'd0);
            check_value("retire_pc", retire_pc, m_pc);
        end
        @(posedge clk);
        #1;
        run = 1'b0;
    endtask

    initial begin
        rst        = 1'b1;
        run        = 1'b0;
        load_en    = 1'b0;
        load_index = '0;
        load_data  = '0;
        m_regs[0]  = '0;

        reset_core();
        build_main_program();
        load_program();
        run_program(halt_ecall, 2000);

        reset_core();
        build_halt_program(instr_ecall);
        load_program();
        run_program(halt_ecall, 100);

        reset_core();
        build_halt_program(instr_ebreak);
        load_program();
        run_program(halt_ebreak, 100);

        reset_core();
        build_halt_program(32'h0000_0000);      // All-zero word is illegal
        load_program();
        run_program(halt_illegal, 100);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* hdl/rv32_core.sv */
/* Single-cycle RV32I core top. Connects fetch, decoder, register file, ALU
   and LSU, selects write-back data and drives the retire port. */
module rv32_core import rv32_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        run,
    input  logic        load_en,
    input  logic [9:0]  load_index,
    input  logic [31:0] load_data,
    output logic        halted,
    output logic [1:0]  halt_cause,
    output logic        retire_valid,
    output logic [31:0] retire_pc,
    output logic [4:0]  retire_rd,
    output logic [31:0] retire_data
);

    word_t pc, instr;
    word_t rs1_data, rs2_data;
    word_t alu_result, lsu_data, wb_data;
    logic  branch_taken;
    logic  rf_wr_en;

    decode_if dec_bus ();

    // ==========================================================================
    // Datapath
    // ==========================================================================
    rv32_fetch fetch_inst (
        .clk          (clk),
        .rst          (rst),
        .run          (run),
        .load_en      (load_en),
        .load_index   (load_index),
        .load_data    (load_data),
        .dec          (dec_bus.consumer),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .branch_taken (branch_taken),
        .pc           (pc),
        .instr        (instr),
        .halted       (halted),
        .halt_cause   (halt_cause)
    );

    rv32_decoder decoder_inst (
        .instr (instr),
        .dec   (dec_bus.producer)
    );

    rv32_regfile regfile_inst (
        .clk      (clk),
        .rs1      (dec_bus.rs1),
        .rs2      (dec_bus.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (rf_wr_en),
        .wr_idx   (dec_bus.rd),
        .wr_data  (wb_data)
    );

    rv32_alu alu_inst (
        .dec          (dec_bus.consumer),
        .pc           (pc),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    rv32_lsu lsu_inst (
        .clk       (clk),
        .run       (run),
        .halted    (halted),
        .dec       (dec_bus.consumer),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .load_data (lsu_data)
    );

    // ==========================================================================
    // Write-back and retire
    // ==========================================================================
    assign wb_data  = (dec_bus.op == op_lw) ? lsu_data : alu_result;
    assign rf_wr_en = dec_bus.reg_wr_en && run && !halted;

    assign retire_valid = run && !halted;
    assign retire_pc    = pc;
    assign retire_rd    = rf_wr_en ? dec_bus.rd : '0;   // Zero when nothing is written
    assign retire_data  = rf_wr_en ? wb_data : '0;

endmodule

/* hdl/rv32_lsu.sv */
/* Word-wide data memory. LW reads in the same cycle; SW writes at the edge
   while the core runs. Address bits 11:2 pick the word, so addresses wrap. */
module rv32_lsu import rv32_pkg::*; (
    input  logic       clk,
    input  logic       run,
    input  logic       halted,
    decode_if.consumer dec,
    input  word_t      rs1_data,
    input  word_t      rs2_data,
    output word_t      load_data
);

    word_t    dmem [mem_words];
    word_t    addr;
    mem_idx_t index;
    logic     store;

    assign addr  = rs1_data + dec.imm;        // I or S immediate from decoder
    assign index = addr[mem_index_w+1:2];     // Byte offset ignored
    assign store = run && !halted && (dec.op == op_sw);

    assign load_data = (dec.op == op_lw) ? dmem[index] : '0;

    always_ff @(posedge clk) begin
        if (store) dmem[index] <= rs2_data;
    end

endmodule

/* hdl/rv32_alu.sv */
/* Result and branch decision for the decoded operation. Purely
   combinational; covers U-type, links, compares, shifts and logic. */
module rv32_alu import rv32_pkg::*; (
    decode_if.consumer dec,
    input  word_t      pc,
    input  word_t      rs1_data,
    input  word_t      rs2_data,
    output word_t      result,
    output logic       branch_taken
);

    word_t operand_b;
    logic  lt_s, lt_u;

    // Register form uses rs2, immediate form uses imm
    assign operand_b = (dec.op inside {[op_add:op_and]}) ? rs2_data : dec.imm;
    assign lt_s      = $signed(rs1_data) < $signed(operand_b);
    assign lt_u      = rs1_data < operand_b;

    always_comb begin
        result = '0;
        case (dec.op)
            op_lui:            result = dec.imm;
            op_auipc:          result = pc + dec.imm;
            op_jal, op_jalr:   result = pc + 32'd4;               // Link address
            op_addi, op_add:   result = rs1_data + operand_b;
            op_sub:            result = rs1_data - operand_b;
            op_slti, op_slt:   result = {31'b0, lt_s};
            op_sltiu, op_sltu: result = {31'b0, lt_u};
            op_xori, op_xor:   result = rs1_data ^ operand_b;
            op_ori, op_or:     result = rs1_data | operand_b;
            op_andi, op_and:   result = rs1_data & operand_b;
            op_slli, op_sll:   result = rs1_data << operand_b[4:0];
            op_srli, op_srl:   result = rs1_data >> operand_b[4:0];
            op_srai, op_sra:   result = $signed(rs1_data) >>> operand_b[4:0];
            default:           result = '0;
        endcase
    end

    always_comb begin
        case (dec.op)
            op_beq:  branch_taken = rs1_data == rs2_data;
            op_bne:  branch_taken = rs1_data != rs2_data;
            op_blt:  branch_taken = $signed(rs1_data) < $signed(rs2_data);
            op_bge:  branch_taken = $signed(rs1_data) >= $signed(rs2_data);
            op_bltu: branch_taken = rs1_data < rs2_data;
            op_bgeu: branch_taken = rs1_data >= rs2_data;
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

/* hdl/rv32_regfile.sv */
/* Integer register file, 32 x 32 bits. Two combinational read ports and
   one write port sampled at the rising edge. */
module rv32_regfile import rv32_pkg::*; (
    input  logic     clk,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data
);

    word_t regs [2**reg_addr_w];

    // x0 reads as zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (wr_en) regs[wr_idx] <= wr_data;
    end

    // Decoder filters rd == x0 before the write reaches this port
    a_no_x0_write: assert property (@(posedge clk)
        wr_en |-> wr_idx != '0);

endmodule

/* hdl/rv32_decoder.sv */
/* RV32I instruction decoder. Maps an instruction word to an operation,
   register indices, immediate and write enable; unknown words are illegal. */
module rv32_decoder import rv32_pkg::*; (
    input  word_t      instr,
    decode_if.producer dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    op_t        op;
    word_t      imm;
    logic       writes_rd;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        op  = op_illegal;
        imm = '0;
        case (opcode)
            opc_lui:   begin op = op_lui;   imm = imm_u; end
            opc_auipc: begin op = op_auipc; imm = imm_u; end
            opc_jal:   begin op = op_jal;   imm = imm_j; end
            opc_jalr: begin
                imm = imm_i;
                if (funct3 == 3'b000) op = op_jalr;
            end
            opc_branch: begin
                imm = imm_b;
                case (funct3)
                    3'b000:  op = op_beq;
                    3'b001:  op = op_bne;
                    3'b100:  op = op_blt;
                    3'b101:  op = op_bge;
                    3'b110:  op = op_bltu;
                    3'b111:  op = op_bgeu;
                    default: op = op_illegal;
                endcase
            end
            opc_load: begin
                imm = imm_i;
                if (funct3 == f3_word) op = op_lw;   // Word loads only
            end
            opc_store: begin
                imm = imm_s;
                if (funct3 == f3_word) op = op_sw;
            end
            opc_op_imm: begin
                imm = imm_i;
                case (funct3)
                    3'b000: op = op_addi;
                    3'b010: op = op_slti;
                    3'b011: op = op_sltiu;
                    3'b100: op = op_xori;
                    3'b110: op = op_ori;
                    3'b111: op = op_andi;
                    3'b001: if (funct7 == f7_base) op = op_slli;
                    3'b101: begin
                        if (funct7 == f7_base) op = op_srli;
                        else if (funct7 == f7_alt) op = op_srai;
                    end
                    default: op = op_illegal;
                endcase
            end
            opc_op: begin
                if (funct7 == f7_base) begin
                    case (funct3)
                        3'b000: op = op_add;
                        3'b001: op = op_sll;
                        3'b010: op = op_slt;
                        3'b011: op = op_sltu;
                        3'b100: op = op_xor;
                        3'b101: op = op_srl;
                        3'b110: op = op_or;
                        3'b111: op = op_and;
                        default: op = op_illegal;
                    endcase
                end else if (funct7 == f7_alt) begin
                    if (funct3 == 3'b000) op = op_sub;
                    else if (funct3 == 3'b101) op = op_sra;
                end
            end
            opc_system: begin
                if (instr == instr_ecall) op = op_ecall;
                else if (instr == instr_ebreak) op = op_ebreak;
            end
            default: op = op_illegal;   // FENCE lands here too
        endcase
    end

    always_comb begin
        case (op)
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
            op_sw, op_ecall, op_ebreak, op_illegal: writes_rd = 1'b0;
            default:                                writes_rd = 1'b1;
        endcase
    end

    assign dec.op        = op;
    assign dec.imm       = imm;
    assign dec.rd        = instr[11:7];
    assign dec.rs1       = instr[19:15];
    assign dec.rs2       = instr[24:20];
    assign dec.reg_wr_en = writes_rd && (instr[11:7] != '0);   // x0 never written

endmodule

/* hdl/rv32_fetch.sv */
/* PC, instruction memory with its load port, next-PC selection and the
   halt flag. The instruction is read combinationally from the PC. */
module rv32_fetch import rv32_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        run,
    input  logic        load_en,
    input  mem_idx_t    load_index,
    input  word_t       load_data,
    decode_if.consumer  dec,
    input  word_t       rs1_data,
    input  word_t       rs2_data,
    input  logic        branch_taken,
    output word_t       pc,
    output word_t       instr,
    output logic        halted,
    output halt_cause_t halt_cause
);

    word_t       imem [mem_words];
    word_t       pc_next;
    halt_cause_t cause_next;
    logic        advance;

    assign advance = run && !halted;
    assign instr   = imem[pc[mem_index_w+1:2]];

    always_ff @(posedge clk) begin
        if (load_en) imem[load_index] <= load_data;   // Only while run is low
    end

    always_comb begin
        pc_next = pc + 32'd4;
        if (dec.op == op_jal) begin
            pc_next = pc + dec.imm;
        end else if (dec.op == op_jalr) begin
            pc_next = (rs1_data + dec.imm) & ~32'd1;
        end else if (branch_taken) begin
            pc_next = pc + dec.imm;
        end
    end

    always_comb begin
        case (dec.op)
            op_ecall:   cause_next = halt_ecall;
            op_ebreak:  cause_next = halt_ebreak;
            op_illegal: cause_next = halt_illegal;
            default:    cause_next = halt_none;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= '0;
            halted     <= 1'b0;
            halt_cause <= halt_none;
        end else if (advance) begin
            pc <= word_t'({pc_next[mem_index_w+1:2], 2'b00});   // Wraps at 4 KiB
            if (cause_next != halt_none) begin
                halted     <= 1'b1;
                halt_cause <= cause_next;
            end
        end
    end

    // ==========================================================================
    // Checks
    // ==========================================================================
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        run |=> pc[1:0] == 2'b00);

    a_load_idle: assert property (@(posedge clk) disable iff (rst)
        load_en |-> !run);

endmodule

/* hdl/decode_if.sv */
/* Decoded instruction fields, driven by the decoder and read by fetch, ALU
   and LSU. All signals settle within the same cycle. */
interface decode_if import rv32_pkg::*; ();

    op_t      op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm;          // Already sign extended and shifted
    logic     reg_wr_en;    // Low for rd == x0

    modport producer (
        output op, rd, rs1, rs2, imm, reg_wr_en
    );

    modport consumer (
        input op, rd, rs1, rs2, imm, reg_wr_en
    );

endinterface

/* hdl/rv32_pkg.sv */
/* Widths, memory sizes, RV32I encodings and operation enums for the core.
   Every RTL file of the core imports this package in its module header. */
package rv32_pkg;

    // ==========================================================================
    // Widths and sizes
    // ==========================================================================
    localparam int xlen        = 32;
    localparam int reg_addr_w  = 5;
    localparam int mem_words   = 1024;
    localparam int mem_index_w = 10;    // log2 of mem_words

    typedef logic [xlen-1:0]        word_t;
    typedef logic [reg_addr_w-1:0]  reg_idx_t;
    typedef logic [mem_index_w-1:0] mem_idx_t;

    // ==========================================================================
    // Instruction encodings
    // ==========================================================================
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_system = 7'b1110011;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;   // SUB, SRA, SRAI
    localparam logic [2:0] f3_word = 3'b010;       // LW, SW

    localparam word_t instr_ecall  = 32'h0000_0073;
    localparam word_t instr_ebreak = 32'h0010_0073;

    // Decoded operation, one value per kept instruction
    typedef enum logic [5:0] {
        op_lui, op_auipc, op_jal, op_jalr,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_lw, op_sw,
        op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
        op_slli, op_srli, op_srai,
        op_add, op_sub, op_sll, op_slt, op_sltu, op_xor,
        op_srl, op_sra, op_or, op_and,
        op_ecall, op_ebreak, op_illegal
    } op_t;

    typedef enum logic [1:0] {
        halt_none    = 2'd0,
        halt_ecall   = 2'd1,
        halt_ebreak  = 2'd2,
        halt_illegal = 2'd3
    } halt_cause_t;

endpackage
